/* hdl/silencer_pkg.sv */
// **********************************************************************
// Shared sizes, latencies, reset defaults and state types of the
// output silencer. Imported by every design module.
// **********************************************************************

package silencer_pkg;

  // **********************************************************************
  // Sizes and latencies
  // **********************************************************************

  localparam int NUM_TRANS = 16;                  // Transducers per frame.
  localparam int IDX_W = $clog2(NUM_TRANS);
  localparam int DIV_LATENCY = 16;                // One stage per quotient bit.
  localparam int PIPE_LATENCY = DIV_LATENCY + 6;  // Input item to output item.

  // Completion-step counts after reset.
  localparam logic [15:0] DEFAULT_STEPS_INTENSITY = 16'd10;
  localparam logic [15:0] DEFAULT_STEPS_PHASE = 16'd40;

  // **********************************************************************
  // Types
  // **********************************************************************

  typedef enum logic {
    CALC_IDLE,
    CALC_RUN
  } calc_state_t;

  typedef enum logic {
    CFG_IDLE,
    CFG_ACK
  } cfg_state_t;

  typedef enum logic {
    SEL_INTENSITY,
    SEL_PHASE
  } cfg_sel_t;

endpackage

/* hdl/step_divider.sv */
// **********************************************************************
// Pipelined 16 by 16 unsigned restoring divider.
// Takes operands every cycle, result after DIV_LATENCY cycles.
// **********************************************************************

`timescale 1ns/1ps

module step_divider
  import silencer_pkg::*;
(
  input  logic        CLK,
  input  logic        rst_n,
  input  logic [15:0] dividend,
  input  logic [15:0] divisor,
  output logic [15:0] quotient,
  output logic [15:0] remainder
);

  // Stage registers. acc holds the dividend bits still to be consumed in
  // its upper part and the quotient bits found so far in its lower part.
  logic [15:0] rem_q [DIV_LATENCY];
  logic [15:0] acc_q [DIV_LATENCY];
  logic [15:0] dsr_q [DIV_LATENCY-1];  // Last stage needs no copy.

  // Stage inputs and trial subtraction.
  logic [15:0] rem_in [DIV_LATENCY];
  logic [15:0] acc_in [DIV_LATENCY];
  logic [15:0] dsr_in [DIV_LATENCY];
  logic [16:0] trial [DIV_LATENCY];
  logic        fits [DIV_LATENCY];

  always_comb begin
    rem_in[0] = '0;
    acc_in[0] = dividend;
    dsr_in[0] = divisor;
    for (int s = 1; s < DIV_LATENCY; s++) begin
      rem_in[s] = rem_q[s-1];
      acc_in[s] = acc_q[s-1];
      dsr_in[s] = dsr_q[s-1];
    end
    for (int s = 0; s < DIV_LATENCY; s++) begin
      trial[s] = {rem_in[s], acc_in[s][15]};       // Bring down next bit.
      fits[s] = trial[s] >= {1'b0, dsr_in[s]};
    end
  end

  always_ff @(posedge CLK) begin
    if (!rst_n) begin
      for (int s = 0; s < DIV_LATENCY; s++) begin
        rem_q[s] <= '0;
        acc_q[s] <= '0;
      end
      for (int s = 0; s < DIV_LATENCY - 1; s++) begin
        dsr_q[s] <= '0;
      end
    end else begin
      for (int s = 0; s < DIV_LATENCY; s++) begin
        if (fits[s]) begin
          rem_q[s] <= 16'(trial[s] - {1'b0, dsr_in[s]});  // Restore not needed.
        end else begin
          rem_q[s] <= trial[s][15:0];
        end
        acc_q[s] <= {acc_in[s][14:0], fits[s]};
      end
      for (int s = 0; s < DIV_LATENCY - 1; s++) begin
        dsr_q[s] <= dsr_in[s];
      end
    end
  end

  assign quotient = acc_q[DIV_LATENCY-1];
  assign remainder = rem_q[DIV_LATENCY-1];

endmodule

/* hdl/step_calculator.sv */
// **********************************************************************
// Per-transducer step calculator. Finds the change of intensity and
// phase against the stored targets, divides by the completion steps and
// spreads the remainder over later frames as update rates.
// **********************************************************************

`timescale 1ns/1ps

module step_calculator
  import silencer_pkg::*;
(
  input  logic        CLK,
  input  logic        rst_n,
  input  logic        din_valid,
  input  logic [15:0] intensity_in,
  input  logic [7:0]  phase_in,
  input  logic [15:0] steps_intensity,
  input  logic [15:0] steps_phase,
  output logic [15:0] intensity_out,
  output logic [15:0] phase_out,
  output logic [15:0] update_rate_intensity,
  output logic [15:0] update_rate_phase,
  output logic        dout_valid
);

  calc_state_t      state;
  logic             in_open;
  logic             accept;
  logic [IDX_W-1:0] in_idx, idx1, wb_idx, out_idx;
  logic [15:0]      steps_int_lat, steps_ph_lat;

  // Delay lines, element k holds the item accepted k cycles earlier.
  logic        vld [PIPE_LATENCY-1];
  logic [15:0] int_dly [PIPE_LATENCY-1];
  logic [7:0]  ph_dly [PIPE_LATENCY-1];
  logic        chg_int [DIV_LATENCY+3];
  logic        chg_ph [DIV_LATENCY+3];

  // Per-transducer state.
  logic [15:0] tgt_int [NUM_TRANS];
  logic [7:0]  tgt_ph [NUM_TRANS];
  logic [15:0] dif_int [NUM_TRANS];
  logic [7:0]  dif_ph [NUM_TRANS];
  logic [15:0] rem_int [NUM_TRANS];
  logic [15:0] rem_ph [NUM_TRANS];

  logic [15:0] adiff_int, sel_int, dvd_int;
  logic [7:0]  adiff_ph, sel_ph, fold_ph;
  logic [15:0] dvd_ph;
  logic [15:0] q_int, r_int, q_ph, r_ph;
  logic [31:0] nxt_int, nxt_ph;
  logic [15:0] rate_int, rate_ph;

  // Rate and next stored remainder, packed as {rate, remainder}.
  function automatic logic [31:0] next_rate(input logic chg, input logic [15:0] q,
                                             input logic [15:0] r, input logic [15:0] stored);
    logic [15:0] left;
    left = chg ? r : stored;
    if (left == 16'd0) begin
      return {q, 16'd0};
    end
    return {q + 16'd1, left - 16'd1};
  endfunction

  // **********************************************************************
  // Frame control
  // **********************************************************************

  assign accept = din_valid && ((state == CALC_IDLE) || in_open);

  always_ff @(posedge CLK) begin
    if (!rst_n) begin
      state <= CALC_IDLE;
      in_open <= 1'b0;
      in_idx <= '0;
    end else begin
      case (state)
        CALC_IDLE: begin
          if (din_valid) begin
            state <= CALC_RUN;
            in_open <= 1'b1;
          end
        end
        CALC_RUN: begin
          if (dout_valid && !vld[PIPE_LATENCY-2]) state <= CALC_IDLE;  // Last output.
        end
        default: state <= CALC_IDLE;
      endcase
      if (accept) begin
        in_idx <= in_idx + 1'b1;
        if (in_idx == IDX_W'(NUM_TRANS - 1)) in_open <= 1'b0;
      end
    end
  end

  always_ff @(posedge CLK) begin
    if (state == CALC_IDLE && din_valid) begin  // Held for the whole frame.
      steps_int_lat <= steps_intensity;
      steps_ph_lat <= steps_phase;
    end
  end

  always_ff @(posedge CLK) begin
    if (!rst_n) begin
      for (int k = 0; k < PIPE_LATENCY - 1; k++) vld[k] <= 1'b0;
      dout_valid <= 1'b0;
    end else begin
      vld[0] <= accept;
      for (int k = 1; k < PIPE_LATENCY - 1; k++) vld[k] <= vld[k-1];
      dout_valid <= vld[PIPE_LATENCY-2];
    end
  end

  // **********************************************************************
  // Difference, select and fold
  // **********************************************************************

  assign fold_ph = sel_ph[7] ? 8'd0 - sel_ph : sel_ph;  // Shorter way round.

  always_ff @(posedge CLK) begin
    int_dly[0] <= intensity_in;
    ph_dly[0] <= phase_in;
    for (int k = 1; k < PIPE_LATENCY - 1; k++) begin
      int_dly[k] <= int_dly[k-1];
      ph_dly[k] <= ph_dly[k-1];
    end
    idx1 <= in_idx;
    adiff_int <= (int_dly[0] >= tgt_int[idx1]) ? int_dly[0] - tgt_int[idx1]
                                               : tgt_int[idx1] - int_dly[0];
    adiff_ph <= (ph_dly[0] >= tgt_ph[idx1]) ? ph_dly[0] - tgt_ph[idx1]
                                            : tgt_ph[idx1] - ph_dly[0];
    chg_int[0] <= int_dly[0] != tgt_int[idx1];
    chg_ph[0] <= ph_dly[0] != tgt_ph[idx1];
    for (int k = 1; k < DIV_LATENCY + 3; k++) begin
      chg_int[k] <= chg_int[k-1];
      chg_ph[k] <= chg_ph[k-1];
    end
    sel_int <= chg_int[0] ? adiff_int : dif_int[wb_idx];
    sel_ph <= chg_ph[0] ? adiff_ph : dif_ph[wb_idx];
    dvd_int <= sel_int;
    dvd_ph <= {fold_ph, 8'h00};
    rate_int <= nxt_int[31:16];
    rate_ph <= nxt_ph[31:16];
    intensity_out <= int_dly[PIPE_LATENCY-2];
    phase_out <= {ph_dly[PIPE_LATENCY-2], 8'h00};
    update_rate_intensity <= rate_int;
    update_rate_phase <= rate_ph;
  end

  always_ff @(posedge CLK) begin
    if (!rst_n) begin
      wb_idx <= '0;
      for (int i = 0; i < NUM_TRANS; i++) begin
        tgt_int[i] <= '0;
        tgt_ph[i] <= '0;
        dif_int[i] <= '0;
        dif_ph[i] <= '0;
      end
    end else if (vld[1]) begin
      wb_idx <= wb_idx + 1'b1;
      if (chg_int[0]) begin
        tgt_int[wb_idx] <= int_dly[1];
        dif_int[wb_idx] <= adiff_int;
      end
      if (chg_ph[0]) begin
        tgt_ph[wb_idx] <= ph_dly[1];
        dif_ph[wb_idx] <= adiff_ph;
      end
    end
  end

  // **********************************************************************
  // Divide and remainder distribution
  // **********************************************************************

  step_divider div_intensity (
    .CLK      (CLK),
    .rst_n    (rst_n),
    .dividend (dvd_int),
    .divisor  (steps_int_lat),
    .quotient (q_int),
    .remainder(r_int)
  );

  step_divider div_phase (
    .CLK      (CLK),
    .rst_n    (rst_n),
    .dividend (dvd_ph),
    .divisor  (steps_ph_lat),
    .quotient (q_ph),
    .remainder(r_ph)
  );

  assign nxt_int = next_rate(chg_int[DIV_LATENCY+2], q_int, r_int, rem_int[out_idx]);
  assign nxt_ph = next_rate(chg_ph[DIV_LATENCY+2], q_ph, r_ph, rem_ph[out_idx]);

  always_ff @(posedge CLK) begin
    if (!rst_n) begin
      out_idx <= '0;
      for (int i = 0; i < NUM_TRANS; i++) begin
        rem_int[i] <= '0;
        rem_ph[i] <= '0;
      end
    end else if (vld[PIPE_LATENCY-3]) begin
      out_idx <= out_idx + 1'b1;
      rem_int[out_idx] <= nxt_int[15:0];
      rem_ph[out_idx] <= nxt_ph[15:0];
    end
  end

endmodule

/* hdl/silencer_config.sv */
// **********************************************************************
// Completion-step registers of the silencer. Software writes them
// over a four-phase req/ack port; a zero write is stored as 1.
// **********************************************************************

`timescale 1ns/1ps

module silencer_config
  import silencer_pkg::*;
(
  input  logic        CLK,
  input  logic        rst_n,
  input  logic        cfg_req,
  input  cfg_sel_t    cfg_sel,
  input  logic [15:0] cfg_data,
  output logic        cfg_ack,
  output logic [15:0] steps_intensity,
  output logic [15:0] steps_phase
);

  cfg_state_t  state;
  logic [15:0] wdata;

  assign wdata = (cfg_data == 16'd0) ? 16'd1 : cfg_data;  // Divisor never zero.
  assign cfg_ack = (state == CFG_ACK);

  always_ff @(posedge CLK) begin
    if (!rst_n) begin
      state <= CFG_IDLE;
      steps_intensity <= DEFAULT_STEPS_INTENSITY;
      steps_phase <= DEFAULT_STEPS_PHASE;
    end else begin
      case (state)
        CFG_IDLE: begin
          if (cfg_req) begin
            if (cfg_sel == SEL_PHASE) begin
              steps_phase <= wdata;
            end else begin
              steps_intensity <= wdata;
            end
            state <= CFG_ACK;  // Ack on the next clock.
          end
        end
        CFG_ACK: begin
          if (!cfg_req) state <= CFG_IDLE;  // Host has seen the ack.
        end
        default: state <= CFG_IDLE;
      endcase
    end
  end

endmodule

/* hdl/silencer_top.sv */
// **********************************************************************
// Output silencer top level. Joins the step configuration block to the
// per-transducer step calculator.
// **********************************************************************

`timescale 1ns/1ps

module silencer_top
  import silencer_pkg::*;
(
  input  logic        CLK,
  input  logic        rst_n,
  input  logic        cfg_req,
  input  cfg_sel_t    cfg_sel,
  input  logic [15:0] cfg_data,
  output logic        cfg_ack,
  input  logic        din_valid,
  input  logic [15:0] intensity_in,
  input  logic [7:0]  phase_in,
  output logic [15:0] intensity_out,
  output logic [15:0] phase_out,
  output logic [15:0] update_rate_intensity,
  output logic [15:0] update_rate_phase,
  output logic        dout_valid
);

  logic [15:0] steps_intensity;
  logic [15:0] steps_phase;

  silencer_config silencer_config_inst (
    .CLK            (CLK),
    .rst_n          (rst_n),
    .cfg_req        (cfg_req),
    .cfg_sel        (cfg_sel),
    .cfg_data       (cfg_data),
    .cfg_ack        (cfg_ack),
    .steps_intensity(steps_intensity),
    .steps_phase    (steps_phase)
  );

  step_calculator step_calculator_inst (
    .CLK                  (CLK),
    .rst_n                (rst_n),
    .din_valid            (din_valid),
    .intensity_in         (intensity_in),
    .phase_in             (phase_in),
    .steps_intensity      (steps_intensity),
    .steps_phase          (steps_phase),
    .intensity_out        (intensity_out),
    .phase_out            (phase_out),
    .update_rate_intensity(update_rate_intensity),
    .update_rate_phase    (update_rate_phase),
    .dout_valid           (dout_valid)
  );

endmodule

/* testbench/silencer_asserts.sv */
// **********************************************************************
// Handshake and stream assertions, bound to the silencer top level.
// **********************************************************************

`timescale 1ns/1ps

module silencer_asserts
  import silencer_pkg::*;
(
  input logic CLK,
  input logic rst_n,
  input logic cfg_req,
  input logic cfg_ack,
  input logic dout_valid
);

  int assert_errors = 0;  // Failed assertions so far.
  int run_len;            // Length of the current dout_valid run.

  always @(posedge CLK) begin
    if (!rst_n) begin
      run_len <= 0;
    end else if (dout_valid) begin
      run_len <= run_len + 1;
    end else begin
      run_len <= 0;
    end
  end

  ack_rise: assert property (@(posedge CLK) disable iff (!rst_n)
    $rose(cfg_ack) |-> $past(cfg_req))
    else begin
      $error("cfg_ack rose while cfg_req was low");
      assert_errors++;
    end

  ack_fall: assert property (@(posedge CLK) disable iff (!rst_n)
    $fell(cfg_ack) |-> !$past(cfg_req))
    else begin
      $error("cfg_ack fell while cfg_req was still high");
      assert_errors++;
    end

  reset_clear: assert property (@(posedge CLK)
    $rose(rst_n) |-> !dout_valid && !cfg_ack)
    else begin
      $error("dout_valid or cfg_ack high after reset");
      assert_errors++;
    end

  run_not_long: assert property (@(posedge CLK) disable iff (!rst_n)
    dout_valid |-> run_len < NUM_TRANS)
    else begin
      $error("dout_valid run longer than one frame");
      assert_errors++;
    end

  run_not_short: assert property (@(posedge CLK) disable iff (!rst_n)
    $fell(dout_valid) |-> run_len == NUM_TRANS)
    else begin
      $error("dout_valid run shorter than one frame");
      assert_errors++;
    end

endmodule

bind silencer_top silencer_asserts silencer_asserts_inst (
  .CLK       (CLK),
  .rst_n     (rst_n),
  .cfg_req   (cfg_req),
  .cfg_ack   (cfg_ack),
  .dout_valid(dout_valid)
);

/* testbench/silencer_tb.sv */
// **********************************************************************
// Testbench of the output silencer. Writes the step counts, streams
// frames and checks every output item against a reference model.
// **********************************************************************

`timescale 1ns/1ps

module silencer_tb
  import silencer_pkg::*;
();

  localparam int WAIT_LIMIT = 200;  // Cycles any single wait may take.

  logic        CLK;
  logic        rst_n;
  logic        cfg_req;
  cfg_sel_t    cfg_sel;
  logic [15:0] cfg_data;
  logic        cfg_ack;
  logic        din_valid;
  logic [15:0] intensity_in;
  logic [7:0]  phase_in;
  logic [15:0] intensity_out;
  logic [15:0] phase_out;
  logic [15:0] update_rate_intensity;
  logic [15:0] update_rate_phase;
  logic        dout_valid;

  string       test_name;
  int          cyc = 0;
  int          frame_start;
  int          items_checked = 0;
  logic [63:0] exp_q [$];  // {intensity, phase, rate intensity, rate phase}.
  logic [15:0] frame_int [NUM_TRANS];
  logic [7:0]  frame_ph [NUM_TRANS];

  // Reference model state.
  logic [15:0] m_tgt_int [NUM_TRANS];
  logic [7:0]  m_tgt_ph [NUM_TRANS];
  logic [15:0] m_dif_int [NUM_TRANS];
  logic [15:0] m_dif_ph [NUM_TRANS];  // Folded and shifted.
  logic [15:0] m_rem_int [NUM_TRANS];
  logic [15:0] m_rem_ph [NUM_TRANS];
  logic [15:0] m_steps_int;
  logic [15:0] m_steps_ph;

  silencer_top silencer_top_inst (
    .CLK                  (CLK),
    .rst_n                (rst_n),
    .cfg_req              (cfg_req),
    .cfg_sel              (cfg_sel),
    .cfg_data             (cfg_data),
    .cfg_ack              (cfg_ack),
    .din_valid            (din_valid),
    .intensity_in         (intensity_in),
    .phase_in             (phase_in),
    .intensity_out        (intensity_out),
    .phase_out            (phase_out),
    .update_rate_intensity(update_rate_intensity),
    .update_rate_phase    (update_rate_phase),
    .dout_valid           (dout_valid)
  );

  initial begin
    CLK = 1'b0;
    forever #10 CLK = ~CLK;
  end

  always @(posedge CLK) cyc <= cyc + 1;

  // **********************************************************************
  // Reference model
  // **********************************************************************

  function automatic logic [63:0] expected_item(input int idx, input logic [15:0] inten,
                                                input logic [7:0] ph);
    logic [15:0] rate_i;
    logic [15:0] rate_p;
    logic [7:0]  d8;
    // A new value restarts the difference and the remainder.
    if (inten != m_tgt_int[idx]) begin
      m_dif_int[idx] = (inten > m_tgt_int[idx]) ? inten - m_tgt_int[idx]
                                                : m_tgt_int[idx] - inten;
      m_tgt_int[idx] = inten;
      m_rem_int[idx] = m_dif_int[idx] % m_steps_int;
    end
    rate_i = m_dif_int[idx] / m_steps_int;
    if (m_rem_int[idx] != 16'd0) begin
      rate_i = rate_i + 16'd1;
      m_rem_int[idx] = m_rem_int[idx] - 16'd1;
    end
    if (ph != m_tgt_ph[idx]) begin
      d8 = (ph > m_tgt_ph[idx]) ? ph - m_tgt_ph[idx] : m_tgt_ph[idx] - ph;
      if (d8 >= 8'd128) d8 = 8'(256 - int'(d8));  // Shorter way round.
      m_dif_ph[idx] = {d8, 8'h00};
      m_tgt_ph[idx] = ph;
      m_rem_ph[idx] = m_dif_ph[idx] % m_steps_ph;
    end
    rate_p = m_dif_ph[idx] / m_steps_ph;
    if (m_rem_ph[idx] != 16'd0) begin
      rate_p = rate_p + 16'd1;
      m_rem_ph[idx] = m_rem_ph[idx] - 16'd1;
    end
    return {inten, ph, 8'h00, rate_i, rate_p};
  endfunction

  // **********************************************************************
  // Checks
  // **********************************************************************

  task automatic stop_on_error();
    $display("FAIL: see errors above");
    $fatal(1, "Simulation stopped at the first error.");
  endtask

  task automatic check_intensity(input string name, input logic [15:0] exp,
                                 input logic [15:0] act);
    if (act !== exp) begin
      $display("CHECK FAILED %s intensity_out: expected %0d actual %0d", name, exp, act);
      stop_on_error();
    end
  endtask

  task automatic check_phase(input string name, input logic [15:0] exp,
                             input logic [15:0] act);
    if (act !== exp) begin
      $display("CHECK FAILED %s phase_out: expected %0d actual %0d", name, exp, act);
      stop_on_error();
    end
  endtask

  task automatic check_rate(input string name, input logic [15:0] exp,
                            input logic [15:0] act);
    if (act !== exp) begin
      $display("CHECK FAILED %s: expected %0d actual %0d", name, exp, act);
      stop_on_error();
    end
  endtask

  task automatic check_latency(input string name, input int exp, input int act);
    if (act != exp) begin
      $display("CHECK FAILED %s latency: expected %0d actual %0d", name, exp, act);
      stop_on_error();
    end
  endtask

  always @(negedge CLK) begin
    logic [63:0] e;
    if (rst_n === 1'b1 && dout_valid === 1'b1) begin
      if (exp_q.size() == 0) begin
        $display("Extra output item in %s, dout_valid high with none expected", test_name);
        stop_on_error();
      end else begin
        e = exp_q.pop_front();
        if (items_checked % NUM_TRANS == 0) begin
          check_latency(test_name, PIPE_LATENCY, cyc - frame_start);
        end
        check_intensity(test_name, e[63:48], intensity_out);
        check_phase(test_name, e[47:32], phase_out);
        check_rate({test_name, " update_rate_intensity"}, e[31:16], update_rate_intensity);
        check_rate({test_name, " update_rate_phase"}, e[15:0], update_rate_phase);
        items_checked++;
      end
    end
  end

  // **********************************************************************
  // Stimulus
  // **********************************************************************

  task automatic write_cfg(input cfg_sel_t sel, input logic [15:0] data);
    int n;
    @(negedge CLK);
    cfg_sel = sel;
    cfg_data = data;
    cfg_req = 1'b1;
    n = 0;
    while (cfg_ack !== 1'b1) begin
      if (n == WAIT_LIMIT) begin
        $display("Timeout in %s, cfg_ack never rose after cfg_req", test_name);
        stop_on_error();
      end
      n++;
      @(negedge CLK);
    end
    cfg_req = 1'b0;
    n = 0;
    while (cfg_ack !== 1'b0) begin
      if (n == WAIT_LIMIT) begin
        $display("Timeout in %s, cfg_ack stayed high after cfg_req dropped", test_name);
        stop_on_error();
      end
      n++;
      @(negedge CLK);
    end
    if (sel == SEL_PHASE) begin
      m_steps_ph = (data == 16'd0) ? 16'd1 : data;  // Zero is stored as 1.
    end else begin
      m_steps_int = (data == 16'd0) ? 16'd1 : data;
    end
  endtask

  task automatic drain_outputs();
    int n;
    n = 0;
    while (exp_q.size() != 0) begin
      if (n == WAIT_LIMIT) begin
        $display("Timeout in %s, %0d output items never came", test_name, exp_q.size());
        stop_on_error();
      end
      n++;
      @(posedge CLK);
    end
    repeat (4) @(negedge CLK);  // Idle gap that also exposes extra items.
  endtask

  task automatic send_frame();
    for (int i = 0; i < NUM_TRANS; i++) begin
      @(negedge CLK);
      if (i == 0) frame_start = cyc;
      din_valid = 1'b1;
      intensity_in = frame_int[i];
      phase_in = frame_ph[i];
      exp_q.push_back(expected_item(i, frame_int[i], frame_ph[i]));
    end
    @(negedge CLK);
    din_valid = 1'b0;
    drain_outputs();
  endtask

  task automatic fill_random_frame();
    for (int i = 0; i < NUM_TRANS; i++) begin
      frame_int[i] = 16'($urandom);
      frame_ph[i] = 8'($urandom);
    end
  endtask

  initial begin
    void'($urandom(32'h63e2f770));
    rst_n = 1'b0;
    cfg_req = 1'b0;
    cfg_sel = SEL_INTENSITY;
    cfg_data = 16'd0;
    din_valid = 1'b0;
    intensity_in = 16'd0;
    phase_in = 8'd0;
    frame_start = 0;
    test_name = "reset";
    m_steps_int = DEFAULT_STEPS_INTENSITY;
    m_steps_ph = DEFAULT_STEPS_PHASE;
    for (int i = 0; i < NUM_TRANS; i++) begin
      m_tgt_int[i] = '0;
      m_tgt_ph[i] = '0;
      m_dif_int[i] = '0;
      m_dif_ph[i] = '0;
      m_rem_int[i] = '0;
      m_rem_ph[i] = '0;
    end
    repeat (5) @(negedge CLK);
    rst_n = 1'b1;

    test_name = "first_frame";
    fill_random_frame();
    send_frame();

    test_name = "config_writes";
    write_cfg(SEL_INTENSITY, 16'($urandom_range(1, 300)));
    write_cfg(SEL_PHASE, 16'd0);
    fill_random_frame();
    send_frame();
    write_cfg(SEL_PHASE, 16'($urandom_range(1, 600)));
    fill_random_frame();
    send_frame();

    test_name = "changed_values";
    repeat (3) begin
      fill_random_frame();
      send_frame();
    end

    // Small counts so that every remainder runs out within the repeats.
    test_name = "remainder_spread";
    write_cfg(SEL_INTENSITY, 16'($urandom_range(3, 8)));
    write_cfg(SEL_PHASE, 16'($urandom_range(3, 8)));
    fill_random_frame();
    send_frame();
    repeat (9) send_frame();

    test_name = "phase_fold";
    for (int i = 0; i < NUM_TRANS; i++) frame_ph[i] = 8'(250 - i);
    send_frame();
    for (int i = 0; i < NUM_TRANS; i++) frame_ph[i] = 8'(5 + i);
    send_frame();
    for (int i = 0; i < NUM_TRANS; i++) frame_ph[i] = 8'(10 + i);
    send_frame();
    for (int i = 0; i < NUM_TRANS; i++) frame_ph[i] = 8'(200 - i);
    send_frame();

    if (silencer_top_inst.silencer_asserts_inst.assert_errors == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("Assertions failed during the run, %0d failures after %0d items checked",
               silencer_top_inst.silencer_asserts_inst.assert_errors, items_checked);
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

/* list.f */
hdl/silencer_pkg.sv
hdl/step_divider.sv
hdl/step_calculator.sv
hdl/silencer_config.sv
hdl/silencer_top.sv
testbench/silencer_asserts.sv
testbench/silencer_tb.sv

/* Makefile */
# Verilator flow for the output silencer.
# Any variable can be set on the command line, e.g. make sim LOG=run.log

VERILATOR ?= verilator
TOP       ?= silencer_tb
FILELIST  ?= list.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= PASS: all tests
VFLAGS    ?= --timing --assert
JOBS      ?= 0
SIM_ARGS  ?= +verilator+error+limit+100

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -j $(JOBS) -f $(FILELIST) \
		--top-module $(TOP) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS) 2>&1 | tee $(LOG)
	@if grep -qF "$(PASS_MSG)" $(LOG); then \
		echo "Simulation passed."; \
	else \
		echo "Simulation failed, see $(LOG)."; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
